// File: mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Data path width in bits
`define MIPS_XLEN 32

// Memory depths in 32-bit words
`define MIPS_IMEM_DEPTH 64
`define MIPS_DMEM_DEPTH 64

// Opcode that stops the core once it reaches writeback
`define MIPS_OP_HALT 6'h3f

`endif

// File: mips_pkg.sv
`default_nettype none
`include "mips_settings.svh"

package mips_pkg;

  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_BEQ   = 6'h04,
    OP_ADDIU = 6'h09,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b,
    OP_HALT  = `MIPS_OP_HALT
  } opcode_e;

  // Function field of R-type words
  typedef enum logic [5:0] {
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_SLT  = 6'h2a
  } funct_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } alu_op_e;

  // An all-zero instruction word decodes as a bubble
  typedef struct packed {
    logic [`MIPS_XLEN-1:0] instr;
    logic [`MIPS_XLEN-1:0] pc_plus4;
  } if_id_t;

  typedef struct packed {
    logic [`MIPS_XLEN-1:0] rs_val;
    logic [`MIPS_XLEN-1:0] rt_val;
    logic [`MIPS_XLEN-1:0] imm;
    logic [4:0]            rs;
    logic [4:0]            rt;
    logic [4:0]            rd;
    alu_op_e               alu_op;
    logic                  alu_src_imm;
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic                  is_branch;
    logic                  is_halt;
    logic [`MIPS_XLEN-1:0] pc_plus4;
    logic                  valid;
  } id_ex_t;

  typedef struct packed {
    logic [`MIPS_XLEN-1:0] alu_result;
    logic [`MIPS_XLEN-1:0] store_data;
    logic [4:0]            rd;
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic                  is_halt;
    logic                  valid;
  } ex_mem_t;

  typedef struct packed {
    logic [`MIPS_XLEN-1:0] wb_data;
    logic [4:0]            rd;
    logic                  reg_write;
    logic                  is_halt;
    logic                  valid;
  } mem_wb_t;

endpackage

`default_nettype wire

// File: mips_fetch.sv
`default_nettype none
`timescale 1ns/1ns
`include "mips_settings.svh"

module mips_fetch (
  input  wire                                   clk,
  input  wire                                   i_rst_n,
  input  wire                                   i_load,
  input  wire  [$clog2(`MIPS_IMEM_DEPTH)-1:0]   i_load_addr,
  input  wire  [`MIPS_XLEN-1:0]                 i_load_data,
  input  wire                                   i_stall,
  input  wire                                   i_redirect,
  input  wire  [`MIPS_XLEN-1:0]                 i_redirect_pc,
  input  wire                                   i_halt_seen,
  output mips_pkg::if_id_t                      o_if_id
);

  import mips_pkg::*;

  localparam int IMEM_AW = $clog2(`MIPS_IMEM_DEPTH);
  localparam logic [`MIPS_XLEN-1:0] WORD_BYTES = 4;

  logic [`MIPS_XLEN-1:0] imem [`MIPS_IMEM_DEPTH];
  logic [`MIPS_XLEN-1:0] pc_q;
  logic [`MIPS_XLEN-1:0] pc_plus4;
  logic [`MIPS_XLEN-1:0] fetch_word;
  if_id_t                if_id_q;

  // Program load port, used only while the core is in reset
  always_ff @(posedge clk) begin
    if (i_load) begin
      imem[i_load_addr] <= i_load_data;
    end
  end

  assign pc_plus4   = pc_q + WORD_BYTES;
  assign fetch_word = imem[pc_q[2 +: IMEM_AW]];

  // Redirect first, then halt, then stall
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      pc_q    <= '0;
      if_id_q <= '0;
    end else if (i_redirect) begin
      pc_q    <= i_redirect_pc;
      if_id_q <= '0;
    end else if (i_halt_seen) begin
      if_id_q <= '0;
    end else if (!i_stall) begin
      pc_q    <= pc_plus4;
      if_id_q <= '{instr: fetch_word, pc_plus4: pc_plus4};
    end
  end

  assign o_if_id = if_id_q;

  // Loading while running would change the program under the pipeline
  a_load_only_in_reset: assert property (@(posedge clk) i_rst_n |-> !i_load);

endmodule

`default_nettype wire

// File: mips_decode.sv
`default_nettype none
`timescale 1ns/1ns
`include "mips_settings.svh"

module mips_decode (
  input  wire                 clk,
  input  wire                 i_rst_n,
  input  mips_pkg::if_id_t    i_if_id,
  input  wire                 i_flush,
  input  wire  [4:0]          i_ex_rd,
  input  wire                 i_ex_mem_read,
  input  mips_pkg::mem_wb_t   i_wb,
  output logic                o_stall,
  output logic                o_halt_seen,
  output mips_pkg::id_ex_t    o_id_ex
);

  import mips_pkg::*;

  logic [`MIPS_XLEN-1:0] rf [32];
  logic [`MIPS_XLEN-1:0] instr;
  logic [4:0]            rs;
  logic [4:0]            rt;
  logic [4:0]            dest;
  logic                  rf_we;
  logic                  dec_valid;
  logic                  writes;
  logic                  uses_rs;
  logic                  uses_rt;
  logic                  load_use;
  logic                  halt_q;
  id_ex_t                id_ex_d;
  id_ex_t                id_ex_q;

  assign instr = i_if_id.instr;
  assign rs    = instr[25:21];
  assign rt    = instr[20:16];
  assign rf_we = i_wb.valid && i_wb.reg_write;

  always_ff @(posedge clk) begin
    if (rf_we) begin
      rf[i_wb.rd] <= i_wb.wb_data;
    end
  end

  always_comb begin
    id_ex_d             = '0;
    dec_valid           = 1'b0;
    writes              = 1'b0;
    uses_rs             = 1'b0;
    uses_rt             = 1'b0;
    dest                = rt;
    id_ex_d.alu_op      = ALU_ADD;
    case (opcode_e'(instr[31:26]))
      OP_RTYPE: begin
        dec_valid = 1'b1;
        writes    = 1'b1;
        uses_rs   = 1'b1;
        uses_rt   = 1'b1;
        dest      = instr[15:11];
        case (funct_e'(instr[5:0]))
          FN_ADDU: id_ex_d.alu_op = ALU_ADD;
          FN_SUBU: id_ex_d.alu_op = ALU_SUB;
          FN_AND:  id_ex_d.alu_op = ALU_AND;
          FN_OR:   id_ex_d.alu_op = ALU_OR;
          FN_SLT:  id_ex_d.alu_op = ALU_SLT;
          default: dec_valid = 1'b0;
        endcase
      end
      OP_ADDIU, OP_LW: begin
        dec_valid           = 1'b1;
        writes              = 1'b1;
        uses_rs             = 1'b1;
        id_ex_d.alu_src_imm = 1'b1;
        id_ex_d.mem_read    = (instr[31:26] == OP_LW);
      end
      OP_SW: begin
        dec_valid           = 1'b1;
        uses_rs             = 1'b1;
        uses_rt             = 1'b1;
        id_ex_d.alu_src_imm = 1'b1;
        id_ex_d.mem_write   = 1'b1;
      end
      OP_BEQ: begin
        dec_valid         = 1'b1;
        uses_rs           = 1'b1;
        uses_rt           = 1'b1;
        id_ex_d.is_branch = 1'b1;
        id_ex_d.alu_op    = ALU_SUB;
      end
      OP_HALT: begin
        dec_valid       = 1'b1;
        id_ex_d.is_halt = 1'b1;
      end
      default: dec_valid = 1'b0;
    endcase

    // Register reads see a write happening in the same cycle
    id_ex_d.rs_val    = (rs == 5'd0) ? '0 :
                        (rf_we && i_wb.rd == rs) ? i_wb.wb_data : rf[rs];
    id_ex_d.rt_val    = (rt == 5'd0) ? '0 :
                        (rf_we && i_wb.rd == rt) ? i_wb.wb_data : rf[rt];
    id_ex_d.imm       = {{(`MIPS_XLEN-16){instr[15]}}, instr[15:0]};
    id_ex_d.rs        = rs;
    id_ex_d.rt        = rt;
    id_ex_d.rd        = dest;
    id_ex_d.reg_write = writes && (dest != 5'd0);
    id_ex_d.pc_plus4  = i_if_id.pc_plus4;
  end

  // Load in EX whose target the instruction in ID needs
  assign load_use = i_ex_mem_read && (i_ex_rd != 5'd0) &&
                    ((uses_rs && rs == i_ex_rd) || (uses_rt && rt == i_ex_rd));
  assign o_stall  = dec_valid && load_use;

  always_ff @(posedge clk) begin
    id_ex_q       <= id_ex_d;
    id_ex_q.valid <= dec_valid && !load_use && !i_flush && i_rst_n;
  end

  // A halt that survives the flush stops fetching for good
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      halt_q <= 1'b0;
    end else if (dec_valid && id_ex_d.is_halt && !i_flush) begin
      halt_q <= 1'b1;
    end
  end

  assign o_halt_seen = halt_q || (dec_valid && id_ex_d.is_halt);
  assign o_id_ex     = id_ex_q;

  // Writes to $0 are dropped here, so none may come back from writeback
  a_no_write_r0: assert property (@(posedge clk) disable iff (!i_rst_n)
    rf_we |-> i_wb.rd != 5'd0);

endmodule

`default_nettype wire

// File: mips_execute.sv
`default_nettype none
`timescale 1ns/1ns
`include "mips_settings.svh"

module mips_execute (
  input  wire                   clk,
  input  wire                   i_rst_n,
  input  mips_pkg::id_ex_t      i_id_ex,
  input  mips_pkg::mem_wb_t     i_wb,
  output logic                  o_redirect,
  output logic [`MIPS_XLEN-1:0] o_redirect_pc,
  output logic                  o_flush,
  output logic [4:0]            o_ex_rd,
  output logic                  o_ex_mem_read,
  output mips_pkg::ex_mem_t     o_ex_mem
);

  import mips_pkg::*;

  ex_mem_t               ex_mem_d;
  ex_mem_t               ex_mem_q;
  logic [`MIPS_XLEN-1:0] rs_fwd;
  logic [`MIPS_XLEN-1:0] rt_fwd;
  logic [`MIPS_XLEN-1:0] op_b;
  logic [`MIPS_XLEN-1:0] alu_result;
  logic                  taken;

  // EX/MEM holds the younger result, so it is checked last and wins
  function automatic logic [`MIPS_XLEN-1:0] fwd_operand(
    input logic [4:0]            src,
    input logic [`MIPS_XLEN-1:0] reg_val
  );
    logic [`MIPS_XLEN-1:0] val;
    val = reg_val;
    if (i_wb.valid && i_wb.reg_write && i_wb.rd == src) begin
      val = i_wb.wb_data;
    end
    if (ex_mem_q.valid && ex_mem_q.reg_write && ex_mem_q.rd == src) begin
      val = ex_mem_q.alu_result;
    end
    return val;
  endfunction

  always_comb begin
    rs_fwd = fwd_operand(i_id_ex.rs, i_id_ex.rs_val);
    rt_fwd = fwd_operand(i_id_ex.rt, i_id_ex.rt_val);
  end

  assign op_b = i_id_ex.alu_src_imm ? i_id_ex.imm : rt_fwd;

  always_comb begin
    case (i_id_ex.alu_op)
      ALU_ADD: alu_result = rs_fwd + op_b;
      ALU_SUB: alu_result = rs_fwd - op_b;
      ALU_AND: alu_result = rs_fwd & op_b;
      ALU_OR:  alu_result = rs_fwd | op_b;
      ALU_SLT: alu_result = {{(`MIPS_XLEN-1){1'b0}}, $signed(rs_fwd) < $signed(op_b)};
      default: alu_result = '0;
    endcase
  end

  // beq resolves here; target is relative to the following word
  assign taken         = i_id_ex.valid && i_id_ex.is_branch && (rs_fwd == rt_fwd);
  assign o_redirect    = taken;
  assign o_flush       = taken;
  assign o_redirect_pc = i_id_ex.pc_plus4 + {i_id_ex.imm[`MIPS_XLEN-3:0], 2'b00};

  assign o_ex_rd       = i_id_ex.rd;
  assign o_ex_mem_read = i_id_ex.valid && i_id_ex.mem_read;

  always_comb begin
    ex_mem_d.alu_result = alu_result;
    ex_mem_d.store_data = rt_fwd;
    ex_mem_d.rd         = i_id_ex.rd;
    ex_mem_d.reg_write  = i_id_ex.reg_write;
    ex_mem_d.mem_read   = i_id_ex.mem_read;
    ex_mem_d.mem_write  = i_id_ex.mem_write;
    ex_mem_d.is_halt    = i_id_ex.is_halt;
    ex_mem_d.valid      = i_id_ex.valid;
  end

  always_ff @(posedge clk) begin
    ex_mem_q       <= ex_mem_d;
    ex_mem_q.valid <= ex_mem_d.valid && i_rst_n;
  end

  assign o_ex_mem = ex_mem_q;

  // The flush must leave a bubble behind the branch in the next cycle
  a_redirect_from_branch: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_redirect |=> (!i_id_ex.valid && !o_redirect));

endmodule

`default_nettype wire

// File: mips_memory_wb.sv
`default_nettype none
`timescale 1ns/1ns
`include "mips_settings.svh"

module mips_memory_wb (
  input  wire                   clk,
  input  wire                   i_rst_n,
  input  mips_pkg::ex_mem_t     i_ex_mem,
  output mips_pkg::mem_wb_t     o_wb,
  output logic                  o_wb_valid,
  output logic [4:0]            o_wb_reg,
  output logic [`MIPS_XLEN-1:0] o_wb_data,
  output logic                  o_halt
);

  import mips_pkg::*;

  localparam int DMEM_AW = $clog2(`MIPS_DMEM_DEPTH);

  logic [`MIPS_XLEN-1:0] dmem [`MIPS_DMEM_DEPTH];
  logic [DMEM_AW-1:0]    dmem_idx;
  mem_wb_t               mem_wb_d;
  mem_wb_t               mem_wb_q;
  logic                  halt_q;

  // Word index from the bits above the byte offset
  assign dmem_idx = i_ex_mem.alu_result[2 +: DMEM_AW];

  always_ff @(posedge clk) begin
    if (i_ex_mem.valid && i_ex_mem.mem_write) begin
      dmem[dmem_idx] <= i_ex_mem.store_data;
    end
  end

  always_comb begin
    mem_wb_d.wb_data   = i_ex_mem.mem_read ? dmem[dmem_idx] : i_ex_mem.alu_result;
    mem_wb_d.rd        = i_ex_mem.rd;
    mem_wb_d.reg_write = i_ex_mem.reg_write;
    mem_wb_d.is_halt   = i_ex_mem.is_halt;
    mem_wb_d.valid     = i_ex_mem.valid;
  end

  always_ff @(posedge clk) begin
    mem_wb_q       <= mem_wb_d;
    mem_wb_q.valid <= mem_wb_d.valid && i_rst_n;
  end

  // Halt stays up until the next reset
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      halt_q <= 1'b0;
    end else begin
      halt_q <= o_halt;
    end
  end

  assign o_halt     = halt_q || (mem_wb_q.valid && mem_wb_q.is_halt);
  assign o_wb       = mem_wb_q;
  assign o_wb_valid = mem_wb_q.valid && mem_wb_q.reg_write;
  assign o_wb_reg   = mem_wb_q.rd;
  assign o_wb_data  = mem_wb_q.wb_data;

endmodule

`default_nettype wire

// File: mips.sv
`default_nettype none
`timescale 1ns/1ns
`include "mips_settings.svh"

module mips (
  input  wire                                   clk,
  input  wire                                   i_rst_n,
  input  wire                                   i_load,
  input  wire  [$clog2(`MIPS_IMEM_DEPTH)-1:0]   i_load_addr,
  input  wire  [`MIPS_XLEN-1:0]                 i_load_data,
  output logic                                  o_wb_valid,
  output logic [4:0]                            o_wb_reg,
  output logic [`MIPS_XLEN-1:0]                 o_wb_data,
  output logic                                  o_halt
);

  import mips_pkg::*;

  if_id_t                if_id;
  id_ex_t                id_ex;
  ex_mem_t               ex_mem;
  mem_wb_t               wb;
  logic                  stall;
  logic                  halt_seen;
  logic                  redirect;
  logic [`MIPS_XLEN-1:0] redirect_pc;
  logic                  flush;
  logic [4:0]            ex_rd;
  logic                  ex_mem_read;

  mips_fetch u_fetch (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_load        (i_load),
    .i_load_addr   (i_load_addr),
    .i_load_data   (i_load_data),
    .i_stall       (stall),
    .i_redirect    (redirect),
    .i_redirect_pc (redirect_pc),
    .i_halt_seen   (halt_seen),
    .o_if_id       (if_id)
  );

  mips_decode u_decode (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_if_id       (if_id),
    .i_flush       (flush),
    .i_ex_rd       (ex_rd),
    .i_ex_mem_read (ex_mem_read),
    .i_wb          (wb),
    .o_stall       (stall),
    .o_halt_seen   (halt_seen),
    .o_id_ex       (id_ex)
  );

  // MEM/WB also serves as the older forwarding source
  mips_execute u_execute (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_id_ex       (id_ex),
    .i_wb          (wb),
    .o_redirect    (redirect),
    .o_redirect_pc (redirect_pc),
    .o_flush       (flush),
    .o_ex_rd       (ex_rd),
    .o_ex_mem_read (ex_mem_read),
    .o_ex_mem      (ex_mem)
  );

  mips_memory_wb u_memory_wb (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_ex_mem      (ex_mem),
    .o_wb          (wb),
    .o_wb_valid    (o_wb_valid),
    .o_wb_reg      (o_wb_reg),
    .o_wb_data     (o_wb_data),
    .o_halt        (o_halt)
  );

endmodule

`default_nettype wire

// File: tb_mips.sv
`default_nettype none
`timescale 1ns/1ns
`include "mips_settings.svh"

module tb_mips;

  localparam int IMEM_AW      = $clog2(`MIPS_IMEM_DEPTH);
  localparam int DMEM_AW      = $clog2(`MIPS_DMEM_DEPTH);
  localparam int RESET_CYCLES = 16;
  localparam int HOLD_CYCLES  = 8;
  localparam int FIRST_WB     = 4;

  // Standard MIPS field values
  localparam logic [5:0] OPC_RTYPE = 6'h00;
  localparam logic [5:0] OPC_BEQ   = 6'h04;
  localparam logic [5:0] OPC_ADDIU = 6'h09;
  localparam logic [5:0] OPC_LW    = 6'h23;
  localparam logic [5:0] OPC_SW    = 6'h2b;
  localparam logic [5:0] OPC_HALT  = `MIPS_OP_HALT;
  localparam logic [5:0] FUN_ADDU  = 6'h21;
  localparam logic [5:0] FUN_SUBU  = 6'h23;
  localparam logic [5:0] FUN_AND   = 6'h24;
  localparam logic [5:0] FUN_OR    = 6'h25;
  localparam logic [5:0] FUN_SLT   = 6'h2a;

  typedef struct packed {
    logic [4:0]            rd;
    logic [`MIPS_XLEN-1:0] data;
  } wb_entry_t;

  logic                  clk;
  logic                  i_rst_n;
  logic                  i_load;
  logic [IMEM_AW-1:0]    i_load_addr;
  logic [`MIPS_XLEN-1:0] i_load_data;
  logic                  o_wb_valid;
  logic [4:0]            o_wb_reg;
  logic [`MIPS_XLEN-1:0] o_wb_data;
  logic                  o_halt;

  logic [31:0] prog [$];
  wb_entry_t   exp_q [$];
  logic [31:0] lfsr_state;
  logic        checking;
  logic        rst_check;
  logic        halt_flag;
  int          run_cycle;
  int          first_wb_cycle;
  int          test_errors;
  int          total_errors;
  int          check_count;
  int          tests_run;
  int          tests_failed;

  mips UUT (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_load      (i_load),
    .i_load_addr (i_load_addr),
    .i_load_data (i_load_data),
    .o_wb_valid  (o_wb_valid),
    .o_wb_reg    (o_wb_reg),
    .o_wb_data   (o_wb_data),
    .o_halt      (o_halt)
  );

  always #10 clk = ~clk;

  function automatic void note_error();
    test_errors++;
    total_errors++;
  endfunction

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      bits       = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return bits;
  endfunction

  function automatic void rtype(input logic [5:0] fn, input logic [4:0] rd,
                                input logic [4:0] rs, input logic [4:0] rt);
    prog.push_back({OPC_RTYPE, rs, rt, rd, 5'd0, fn});
  endfunction

  function automatic void itype(input logic [5:0] op, input logic [4:0] rt,
                                input logic [4:0] rs, input logic [15:0] imm);
    prog.push_back({op, rs, rt, imm});
  endfunction

  function automatic void halt_here();
    prog.push_back({OPC_HALT, 26'd0});
  endfunction

  // Instruction-level model, records every register write in program order
  function automatic void run_model();
    logic [`MIPS_XLEN-1:0] regs [32];
    logic [`MIPS_XLEN-1:0] mem [`MIPS_DMEM_DEPTH];
    logic [`MIPS_XLEN-1:0] w;
    logic [`MIPS_XLEN-1:0] a;
    logic [`MIPS_XLEN-1:0] b;
    logic [`MIPS_XLEN-1:0] imm;
    logic [`MIPS_XLEN-1:0] addr;
    logic [`MIPS_XLEN-1:0] res;
    logic [4:0]            dst;
    logic                  wr;
    logic                  done;
    int                    pc;
    int                    steps;
    foreach (regs[k]) regs[k] = '0;
    foreach (mem[k]) mem[k] = '0;
    exp_q.delete();
    pc    = 0;
    steps = 0;
    done  = 1'b0;
    while (!done && pc < prog.size() && steps < 1000) begin
      w    = prog[pc];
      a    = regs[w[25:21]];
      b    = regs[w[20:16]];
      imm  = {{16{w[15]}}, w[15:0]};
      addr = a + imm;
      wr   = 1'b0;
      dst  = w[20:16];
      res  = '0;
      pc++;
      steps++;
      case (w[31:26])
        OPC_RTYPE: begin
          wr  = 1'b1;
          dst = w[15:11];
          case (w[5:0])
            FUN_ADDU: res = a + b;
            FUN_SUBU: res = a - b;
            FUN_AND:  res = a & b;
            FUN_OR:   res = a | b;
            FUN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:  wr = 1'b0;
          endcase
        end
        OPC_ADDIU: begin
          wr  = 1'b1;
          res = addr;
        end
        OPC_LW: begin
          wr  = 1'b1;
          res = mem[addr[2 +: DMEM_AW]];
        end
        OPC_SW:   mem[addr[2 +: DMEM_AW]] = b;
        OPC_BEQ:  if (a == b) pc = pc + int'($signed(imm));
        OPC_HALT: done = 1'b1;
        default:  ;
      endcase
      if (wr && dst != 5'd0) begin
        regs[dst] = res;
        exp_q.push_back('{rd: dst, data: res});
      end
    end
  endfunction

  // Registers and four data words are set up first so nothing reads stale state
  function automatic void build_random();
    logic [5:0] fns [5];
    logic [2:0] kind;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    int         off;
    fns = '{FUN_ADDU, FUN_SUBU, FUN_AND, FUN_OR, FUN_SLT};
    prog.delete();
    for (int r = 1; r < 8; r++) begin
      itype(OPC_ADDIU, 5'(r), 5'd0, 16'(next_bits(16)));
    end
    for (int m = 0; m < 4; m++) begin
      itype(OPC_SW, 5'(m + 1), 5'd0, 16'(m * 4));
    end
    for (int i = 0; i < 40; i++) begin
      kind = 3'(next_bits(3));
      rs   = 5'(next_bits(3));
      rt   = 5'(next_bits(3));
      rd   = 5'(1 + next_bits(3) % 7);
      case (kind)
        3'd0, 3'd1, 3'd2: rtype(fns[next_bits(3) % 5], rd, rs, rt);
        3'd4: itype(OPC_LW, rd, 5'd0, 16'(next_bits(2) * 4));
        3'd5: itype(OPC_SW, rt, 5'd0, 16'(next_bits(2) * 4));
        3'd6: begin
          if (next_bits(1) == 32'd1) rt = rs;
          off = int'(next_bits(2));
          // Forward only, never past the halt
          if (off > 39 - i) off = 39 - i;
          itype(OPC_BEQ, rt, rs, 16'(off));
        end
        default: itype(OPC_ADDIU, rd, rs, 16'(next_bits(16)));
      endcase
    end
    halt_here();
  endfunction

  // Reset lasts at least 16 cycles and covers the whole load
  task automatic load_and_reset();
    int n;
    n              = prog.size() + 2;
    checking       = 1'b0;
    halt_flag      = 1'b0;
    run_cycle      = 0;
    first_wb_cycle = -1;
    i_rst_n        = 1'b0;
    for (int i = 0; i < n || i < RESET_CYCLES; i++) begin
      i_load      = (i < n);
      i_load_addr = IMEM_AW'(i);
      i_load_data = (i < prog.size()) ? prog[i] : {OPC_HALT, 26'(i)};
      if (i == 1) rst_check = 1'b1;
      @(negedge clk);
    end
    i_load    = 1'b0;
    rst_check = 1'b0;
    i_rst_n   = 1'b1;
    checking  = 1'b1;
  endtask

  task automatic run_test(input string name);
    int limit;
    int cyc;
    int expected;
    run_model();
    expected    = exp_q.size();
    test_errors = 0;
    load_and_reset();
    limit = 8 * prog.size() + 50;
    cyc   = 0;
    while (!halt_flag && cyc < limit) begin
      @(negedge clk);
      cyc++;
    end
    if (!halt_flag) begin
      $display("Test %s timed out: o_halt did not rise within %0d cycles", name, limit);
      $display("RESULT: FAIL");
      $finish;
    end else begin
      // Keep watching for late writebacks and a falling halt
      repeat (HOLD_CYCLES) @(negedge clk);
      checking = 1'b0;
      if (exp_q.size() != 0) begin
        $display("Test %s: %0d expected writebacks never appeared", name, exp_q.size());
        note_error();
      end
      if (first_wb_cycle != FIRST_WB) begin
        $display("Error at %0t ns: first writeback in cycle %0d after reset, expected %0d",
                 $time, first_wb_cycle, FIRST_WB);
        note_error();
      end
      tests_run++;
      if (test_errors != 0) tests_failed++;
      $display("Test %0d %s: %s, %0d writebacks, %0d errors", tests_run, name,
               (test_errors == 0) ? "ok" : "FAILED", expected, test_errors);
    end
  endtask

  always @(posedge clk) begin
    wb_entry_t want;
    if (rst_check && (o_wb_valid !== 1'b0 || o_halt !== 1'b0)) begin
      $display("Error at %0t ns: o_wb_valid=%b o_halt=%b during reset", $time, o_wb_valid, o_halt);
      note_error();
    end
    if (checking) begin
      if (o_wb_valid === 1'b1) begin
        if (halt_flag) begin
          $display("Writeback to register %0d appeared after o_halt at %0t ns", o_wb_reg, $time);
          note_error();
        end else if (exp_q.size() == 0) begin
          $display("Extra writeback to register %0d at %0t ns", o_wb_reg, $time);
          note_error();
        end else begin
          want = exp_q.pop_front();
          check_count++;
          if (o_wb_reg !== want.rd || o_wb_data !== want.data) begin
            $display("Error at %0t ns: writeback r%0d=%h, expected r%0d=%h",
                     $time, o_wb_reg, o_wb_data, want.rd, want.data);
            note_error();
          end
        end
        if (first_wb_cycle < 0) first_wb_cycle = run_cycle;
      end else if (o_wb_valid !== 1'b0) begin
        $display("Error at %0t ns: o_wb_valid is %b", $time, o_wb_valid);
        note_error();
      end
      if (halt_flag && o_halt !== 1'b1) begin
        $display("Error at %0t ns: o_halt fell after rising", $time);
        note_error();
      end
      if (o_halt === 1'b1) halt_flag = 1'b1;
      run_cycle++;
    end
  end

  initial begin
    clk            = 1'b0;
    i_rst_n        = 1'b0;
    i_load         = 1'b0;
    i_load_addr    = '0;
    i_load_data    = '0;
    checking       = 1'b0;
    rst_check      = 1'b0;
    halt_flag      = 1'b0;
    run_cycle      = 0;
    first_wb_cycle = -1;
    test_errors    = 0;
    total_errors   = 0;
    check_count    = 0;
    tests_run      = 0;
    tests_failed   = 0;
    lfsr_state     = 32'h82ac_bd0d;
    @(negedge clk);

    // One write, for reset levels and first-writeback latency
    prog.delete();
    itype(OPC_ADDIU, 5'd1, 5'd0, 16'h0055);
    halt_here();
    run_test("reset");

    // Dependent chain through both forwarding paths and the decode bypass
    prog.delete();
    itype(OPC_ADDIU, 5'd1, 5'd0, 16'd5);
    itype(OPC_ADDIU, 5'd2, 5'd1, 16'd7);
    rtype(FUN_ADDU, 5'd3, 5'd2, 5'd1);
    rtype(FUN_SUBU, 5'd4, 5'd1, 5'd3);
    rtype(FUN_AND, 5'd5, 5'd4, 5'd2);
    rtype(FUN_OR, 5'd6, 5'd5, 5'd4);
    rtype(FUN_SLT, 5'd7, 5'd4, 5'd6);
    rtype(FUN_SLT, 5'd8, 5'd6, 5'd4);
    itype(OPC_ADDIU, 5'd9, 5'd4, 16'hffff);
    rtype(FUN_ADDU, 5'd10, 5'd9, 5'd8);
    rtype(FUN_ADDU, 5'd0, 5'd1, 5'd2);
    rtype(FUN_ADDU, 5'd11, 5'd0, 5'd10);
    halt_here();
    run_test("forward");

    // Store, load back, then load-use stalls on ALU and store data
    prog.delete();
    itype(OPC_ADDIU, 5'd1, 5'd0, 16'h1234);
    itype(OPC_ADDIU, 5'd2, 5'd0, 16'd8);
    itype(OPC_SW, 5'd1, 5'd2, 16'd4);
    itype(OPC_LW, 5'd3, 5'd2, 16'd4);
    rtype(FUN_ADDU, 5'd4, 5'd3, 5'd1);
    itype(OPC_LW, 5'd5, 5'd2, 16'd4);
    itype(OPC_SW, 5'd5, 5'd2, 16'd8);
    itype(OPC_LW, 5'd6, 5'd2, 16'd8);
    itype(OPC_ADDIU, 5'd7, 5'd6, 16'd1);
    rtype(FUN_ADDU, 5'd8, 5'd7, 5'd3);
    halt_here();
    run_test("load_use");

    // Taken beq skips two, untaken falls through, last one jumps to the halt
    prog.delete();
    itype(OPC_ADDIU, 5'd1, 5'd0, 16'd3);
    itype(OPC_ADDIU, 5'd2, 5'd0, 16'd3);
    itype(OPC_BEQ, 5'd2, 5'd1, 16'd2);
    itype(OPC_ADDIU, 5'd3, 5'd0, 16'h0111);
    itype(OPC_ADDIU, 5'd4, 5'd0, 16'h0222);
    itype(OPC_ADDIU, 5'd5, 5'd0, 16'h0333);
    itype(OPC_BEQ, 5'd5, 5'd1, 16'd1);
    itype(OPC_ADDIU, 5'd6, 5'd0, 16'h0444);
    itype(OPC_ADDIU, 5'd7, 5'd6, 16'd1);
    itype(OPC_BEQ, 5'd0, 5'd0, 16'd1);
    itype(OPC_ADDIU, 5'd8, 5'd0, 16'h0555);
    halt_here();
    run_test("branch");

    build_random();
    run_test("random");

    // Words after the halt must never execute
    prog.delete();
    itype(OPC_ADDIU, 5'd1, 5'd0, 16'd1);
    itype(OPC_ADDIU, 5'd2, 5'd1, 16'd1);
    halt_here();
    itype(OPC_ADDIU, 5'd3, 5'd0, 16'd3);
    itype(OPC_ADDIU, 5'd4, 5'd0, 16'd4);
    run_test("halt");

    $display("Summary: %0d tests, %0d failed, %0d writebacks checked, %0d errors",
             tests_run, tests_failed, check_count, total_errors);
    if (total_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
mips_pkg.sv
mips_fetch.sv
mips_decode.sv
mips_execute.sv
mips_memory_wb.sv
mips.sv
tb_mips.sv

// File: Bender.yml
package:
  name: mips

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mips_pkg.sv
      - mips_fetch.sv
      - mips_decode.sv
      - mips_execute.sv
      - mips_memory_wb.sv
      - mips.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mips.sv
